// ==== files.f ====
+incdir+common
common/axil_pkg.sv
common/lvda_pkg.sv
design/lvda_timing.sv
design/lvda_regs.sv
din_sampler/lvda_cmd_decode.sv
din_sampler/lvda_din_sampler.sv
design/lvda.sv
dv/lvda_props.sv
dv/lvda_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the lvda testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f files.f --top-module lvda_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vlvda_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if echo "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

// ==== dv/lvda_tb.sv ====
`timescale 1ns/1ps
`include "lvda_cfg.svh"

module lvda_tb
    import axil_pkg::*, lvda_pkg::*;
();

    // 150 frames of at most 45 cycles, plus the register and halt tests, with margin.
    localparam int cycle_limit = 20000;
    localparam int frame_window = 40;

    logic                    sim_clk;
    logic                    rst;
    logic                    pio;
    logic [`LVDA_ADDR_W-1:0] pio_addr;
    logic                    hlt;
    logic                    cst;
    axil_req_t               axil_req;
    axil_rsp_t               axil_rsp;
    serial_out_t             dout;
    logic                    halt;
    logic                    cstn;

    integer     seed;
    int         cycles;
    int         errors;
    int         checks;
    int         tests;
    int         test_errors;
    logic [23:0] din_m;
    logic       en_m;
    int         stb_time[$];
    logic       stb_bit[$];

    lvda uut (
        .sim_clk  (sim_clk),
        .rst      (rst),
        .pio      (pio),
        .pio_addr (pio_addr),
        .hlt      (hlt),
        .cst      (cst),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .dout     (dout),
        .halt     (halt),
        .cstn     (cstn)
    );

    always #5 sim_clk = ~sim_clk;

    always @(posedge sim_clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic step();
        @(posedge sim_clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%0t: %s", $time, what);
        end
    endtask

    function automatic logic [`LVDA_ADDR_W-1:0] cmd_addr(input logic [2:0] op,
                                                       input logic [3:0] mid,
                                                       input logic [1:0] group);
        return {op, mid, group};
    endfunction

    task automatic reg_write(input axil_addr_t addr, input axil_data_t data,
                             input axil_strb_t strb);
        axil_resp_t exp_resp;
        exp_resp = resp_slverr;
        if (addr == `LVDA_REG_DIN || addr == `LVDA_REG_CTRL || addr == `LVDA_REG_STATUS) begin
            exp_resp = resp_okay;
        end
        axil_req.awvalid = 1'b1;
        axil_req.awaddr = addr;
        axil_req.wvalid = 1'b1;
        axil_req.wdata = data;
        axil_req.wstrb = strb;
        #1;
        check_value("awready", 32'(axil_rsp.awready), 32'd1);
        check_value("wready", 32'(axil_rsp.wready), 32'd1);
        step();
        while (!axil_rsp.bvalid) step();
        check_value("bresp", 32'(axil_rsp.bresp), 32'(exp_resp));
        check_value("awready", 32'(axil_rsp.awready), 32'd0);
        check_value("wready", 32'(axil_rsp.wready), 32'd0);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid = 1'b0;
        axil_req.bready = 1'b1;
        step();
        axil_req.bready = 1'b0;
        // byte lanes 0 to 2 carry the 24 discrete inputs.
        if (addr == `LVDA_REG_DIN) begin
            for (int b = 0; b < 3; b++) begin
                if (strb[b]) din_m[8*b +: 8] = data[8*b +: 8];
            end
        end else if (addr == `LVDA_REG_CTRL && strb[0]) begin
            en_m = data[0];
        end
    endtask

    task automatic reg_read_check(input axil_addr_t addr, input axil_data_t exp_data,
                                  input axil_resp_t exp_resp);
        axil_req.arvalid = 1'b1;
        axil_req.araddr = addr;
        #1;
        check_value("arready", 32'(axil_rsp.arready), 32'd1);
        step();
        while (!axil_rsp.rvalid) step();
        check_value("rresp", 32'(axil_rsp.rresp), 32'(exp_resp));
        check_value("rdata", axil_rsp.rdata, exp_data);
        check_value("arready", 32'(axil_rsp.arready), 32'd0);
        axil_req.arvalid = 1'b0;
        axil_req.rready = 1'b1;
        step();
        axil_req.rready = 1'b0;
    endtask

    // pulses pio, optionally a second time at step inject_at, and records every strobe.
    task automatic run_cmd(input logic [`LVDA_ADDR_W-1:0] addr, input int n,
                           input int inject_at, input logic [`LVDA_ADDR_W-1:0] inject_addr);
        stb_time.delete();
        stb_bit.delete();
        pio = 1'b1;
        pio_addr = addr;
        for (int i = 1; i <= n; i++) begin
            step();
            if (dout.data_strobe) begin
                stb_time.push_back(i);
                stb_bit.push_back(dout.data);
            end
            pio = (i == inject_at);
            if (i == inject_at) pio_addr = inject_addr;
        end
        pio = 1'b0;
    endtask

    task automatic check_frame(input int g);
        logic [7:0] slice;
        slice = din_m[8*g +: 8];
        check_value("dout.data_strobe count", 32'(stb_time.size()), 32'd8);
        if (stb_time.size() == 8) begin
            check_true(stb_time[0] >= 2 && stb_time[0] <= 5,
                       "first data strobe not 2 to 5 cycles after pio");
            for (int k = 0; k < 8; k++) begin
                if (k > 0) begin
                    check_true(stb_time[k] - stb_time[k-1] == 4, "data strobes not 4 cycles apart");
                end
                check_value("dout.data", 32'(stb_bit[k]), 32'(slice[7-k]));
            end
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_errors) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        int          g;
        seed = 37487;
        sim_clk = 1'b0;
        rst = 1'b1;
        pio = 1'b0;
        pio_addr = '0;
        hlt = 1'b0;
        cst = 1'b0;
        axil_req = '0;
        din_m = '0;
        en_m = 1'b0;
        cycles = 0;
        errors = 0;
        checks = 0;
        tests = 0;
        test_errors = 0;
        repeat (16) @(posedge sim_clk);
        #1;
        rst = 1'b0;

        check_value("halt", 32'(halt), 32'd0);
        check_value("cstn", 32'(cstn), 32'd1);
        check_value("dout.data_strobe", 32'(dout.data_strobe), 32'd0);
        check_value("bvalid", 32'(axil_rsp.bvalid), 32'd0);
        check_value("rvalid", 32'(axil_rsp.rvalid), 32'd0);
        for (int i = 0; i < 20; i++) begin
            r = $random(seed);
            d = $random(seed);
            reg_write(r[0] ? `LVDA_REG_CTRL : `LVDA_REG_DIN, d, r[4:1]);
            reg_read_check(`LVDA_REG_DIN, 32'(din_m), resp_okay);
            reg_read_check(`LVDA_REG_CTRL, 32'(en_m), resp_okay);
        end
        d = $random(seed);
        reg_write(4'hc, d, 4'hf);
        reg_read_check(4'hc, 32'd0, resp_slverr);
        reg_read_check(`LVDA_REG_DIN, 32'(din_m), resp_okay);
        reg_read_check(`LVDA_REG_CTRL, 32'(en_m), resp_okay);
        end_test("registers");

        for (int i = 0; i < 120; i++) begin
            d = $random(seed);
            r = $random(seed);
            reg_write(`LVDA_REG_DIN, d, 4'hf);
            g = int'(r[7:0]) % 3;
            // a random gap moves the command to a different phase.
            repeat (r[14:13]) step();
            run_cmd(cmd_addr(`LVDA_DIN_READ_OP, r[11:8], 2'(g)), frame_window, 0, '0);
            check_frame(g);
        end
        end_test("frames");

        for (int i = 0; i < 20; i++) begin
            r = $random(seed);
            if (r[2:0] == `LVDA_DIN_READ_OP) begin
                run_cmd(cmd_addr(r[2:0], r[6:3], 2'd3), frame_window, 0, '0);
            end else begin
                run_cmd(cmd_addr(r[2:0], r[6:3], r[8:7]), frame_window, 0, '0);
            end
            check_value("dout.data_strobe count", 32'(stb_time.size()), 32'd0);
        end
        end_test("bad commands");

        for (int i = 0; i < 5; i++) begin
            d = $random(seed);
            r = $random(seed);
            reg_write(`LVDA_REG_DIN, d, 4'hf);
            g = int'(r[7:0]) % 3;
            run_cmd(cmd_addr(`LVDA_DIN_READ_OP, r[11:8], 2'(g)), frame_window,
                    1 + int'(r[15:8]) % 28, cmd_addr(`LVDA_DIN_READ_OP, r[19:16], 2'd2));
            check_frame(g);
        end
        run_cmd(cmd_addr(`LVDA_DIN_READ_OP, 4'h5, 2'd1), 3, 0, '0);
        reg_read_check(`LVDA_REG_STATUS, 32'h2, resp_okay);
        repeat (frame_window) step();
        reg_read_check(`LVDA_REG_STATUS, 32'h0, resp_okay);
        end_test("busy drop");

        reg_write(`LVDA_REG_CTRL, 32'h1, 4'h1);
        r = $random(seed);
        repeat (r[1:0]) step();
        // four cycles of hlt always span one phase Z.
        hlt = 1'b1;
        repeat (4) step();
        hlt = 1'b0;
        check_value("halt", 32'(halt), 32'd1);
        reg_read_check(`LVDA_REG_STATUS, 32'h1, resp_okay);
        cst = 1'b1;
        step();
        check_value("cstn", 32'(cstn), 32'd0);
        check_value("halt", 32'(halt), 32'd0);
        cst = 1'b0;
        step();
        check_value("cstn", 32'(cstn), 32'd1);
        reg_write(`LVDA_REG_CTRL, 32'h0, 4'h1);
        hlt = 1'b1;
        repeat (8) begin
            step();
            check_value("halt", 32'(halt), 32'd0);
        end
        hlt = 1'b0;
        reg_read_check(`LVDA_REG_STATUS, 32'h0, resp_okay);
        end_test("halt");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== dv/lvda_props.sv ====
`timescale 1ns/1ps

module lvda_props
    import axil_pkg::*, lvda_pkg::*;
(
    input logic        sim_clk,
    input logic        rst,
    input phase_t      phase,
    input serial_out_t dout,
    input logic        busy,
    input axil_req_t   axil_req,
    input axil_rsp_t   axil_rsp
);

    // a strobe belongs to phase Z, which always follows phase Y.
    strobe_in_z: assert property (@(posedge sim_clk) disable iff (rst)
        dout.data_strobe |-> $past(phase) == phase_y)
        else $error("data strobe outside phase Z");

    bvalid_held: assert property (@(posedge sim_clk) disable iff (rst)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
        else $error("bvalid dropped before bready");

    rvalid_held: assert property (@(posedge sim_clk) disable iff (rst)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
        else $error("rvalid dropped before rready");

    // the frame ends on the edge after its eighth strobe, 28 cycles after the first.
    busy_end: assert property (@(posedge sim_clk) disable iff (rst)
        $fell(busy) |-> $past(dout.data_strobe) && $past(dout.data_strobe, 29))
        else $error("busy fell without a full frame of strobes");

endmodule

bind lvda_din_sampler lvda_props u_sampler_props (
    .sim_clk  (sim_clk),
    .rst      (rst),
    .phase    (phase),
    .dout     (dout),
    .busy     (busy),
    .axil_req ('0),
    .axil_rsp ('0)
);

bind lvda_regs lvda_props u_regs_props (
    .sim_clk  (sim_clk),
    .rst      (rst),
    .phase    (phase_w),
    .dout     ('0),
    .busy     (1'b0),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp)
);

// ==== design/lvda.sv ====
`timescale 1ns/1ps
`include "lvda_cfg.svh"

module lvda
    import axil_pkg::*, lvda_pkg::*;
(
    input  logic                    sim_clk,
    input  logic                    rst,
    input  logic                    pio,
    input  logic [`LVDA_ADDR_W-1:0] pio_addr,
    input  logic                    hlt,
    input  logic                    cst,
    input  axil_req_t               axil_req,
    output axil_rsp_t               axil_rsp,
    output serial_out_t             dout,
    output logic                    halt,
    output logic                    cstn
);

    phase_t   phase;
    din_req_t req;
    din_t     din;
    logic     halt_en;
    logic     busy;

    lvda_timing u_timing (
        .sim_clk (sim_clk),
        .rst     (rst),
        .hlt     (hlt),
        .cst     (cst),
        .halt_en (halt_en),
        .phase   (phase),
        .halt    (halt),
        .cstn    (cstn)
    );

    lvda_regs u_regs (
        .sim_clk  (sim_clk),
        .rst      (rst),
        .axil_req (axil_req),
        .halt     (halt),
        .busy     (busy),
        .axil_rsp (axil_rsp),
        .din      (din),
        .halt_en  (halt_en)
    );

    lvda_cmd_decode u_decode (
        .sim_clk  (sim_clk),
        .rst      (rst),
        .pio      (pio),
        .pio_addr (pio_addr),
        .busy     (busy),
        .req      (req)
    );

    lvda_din_sampler u_sampler (
        .sim_clk (sim_clk),
        .rst     (rst),
        .req     (req),
        .din     (din),
        .phase   (phase),
        .dout    (dout),
        .busy    (busy)
    );

endmodule

// ==== din_sampler/lvda_din_sampler.sv ====
`timescale 1ns/1ps
`include "lvda_cfg.svh"

module lvda_din_sampler
    import lvda_pkg::*;
(
    input  logic        sim_clk,
    input  logic        rst,
    input  din_req_t    req,
    input  din_t        din,
    input  phase_t      phase,
    output serial_out_t dout,
    output logic        busy
);

    localparam int cnt_w = $clog2(`LVDA_GROUP_W);

    din_group_t               group;
    logic                     loaded;
    logic [cnt_w-1:0]         bit_cnt;
    logic [`LVDA_GROUP_W-1:0] slice;
    logic [`LVDA_GROUP_W-1:0] shreg;
    logic                     fire;

    assign slice = din[group * `LVDA_GROUP_W +: `LVDA_GROUP_W];
    assign fire = busy && (phase == phase_z);

    // the first bit comes straight from the slice while it is being loaded.
    assign dout = '{
        data:        loaded ? shreg[`LVDA_GROUP_W-1] : slice[`LVDA_GROUP_W-1],
        data_strobe: fire
    };

    always_ff @(posedge sim_clk) begin
        if (rst) begin
            busy <= 1'b0;
            loaded <= 1'b0;
            bit_cnt <= '0;
        end else if (!busy) begin
            if (req.valid) begin
                busy <= 1'b1;
                loaded <= 1'b0;
                bit_cnt <= '0;
            end
        end else if (phase == phase_z) begin
            loaded <= 1'b1;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == cnt_w'(`LVDA_GROUP_W - 1)) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge sim_clk) begin
        if (!busy && req.valid) begin
            group <= req.group;
        end
        if (fire) begin
            shreg <= (loaded ? shreg : slice) << 1;
        end
    end

endmodule

// ==== din_sampler/lvda_cmd_decode.sv ====
`timescale 1ns/1ps
`include "lvda_cfg.svh"

module lvda_cmd_decode
    import lvda_pkg::*;
(
    input  logic                    sim_clk,
    input  logic                    rst,
    input  logic                    pio,
    input  logic [`LVDA_ADDR_W-1:0] pio_addr,
    input  logic                    busy,
    output din_req_t                req
);

    localparam int group_cnt = `LVDA_DIN_W / `LVDA_GROUP_W;

    din_group_t group;
    logic       op_hit;
    logic       group_ok;
    logic       accept;

    assign group = pio_addr[$bits(din_group_t)-1:0];
    assign op_hit = pio_addr[`LVDA_ADDR_W-1 -: 3] == `LVDA_DIN_READ_OP;
    assign group_ok = int'(group) < group_cnt;

    // busy rises a cycle after the request, so a request still in flight also blocks.
    assign accept = pio && op_hit && group_ok && !busy && !req.valid;

    always_ff @(posedge sim_clk) begin
        if (rst) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= accept;
        end
        if (accept) begin
            req.group <= group;
        end
    end

endmodule

// ==== design/lvda_regs.sv ====
`timescale 1ns/1ps
`include "lvda_cfg.svh"

module lvda_regs
    import axil_pkg::*, lvda_pkg::*;
(
    input  logic      sim_clk,
    input  logic      rst,
    input  axil_req_t axil_req,
    input  logic      halt,
    input  logic      busy,
    output axil_rsp_t axil_rsp,
    output din_t      din,
    output logic      halt_en
);

    logic       wr_go;
    logic       rd_go;
    logic       wr_hit;
    logic       bvalid;
    logic       rvalid;
    axil_resp_t bresp;
    axil_resp_t rresp;
    axil_data_t rdata;
    axil_data_t status;

    // address and data must arrive together; only one response is outstanding.
    assign wr_go = axil_req.awvalid && axil_req.wvalid && !bvalid;
    assign rd_go = axil_req.arvalid && !rvalid;
    assign status = {30'd0, busy, halt};

    always_comb begin
        case (axil_req.awaddr)
            `LVDA_REG_DIN, `LVDA_REG_CTRL, `LVDA_REG_STATUS: wr_hit = 1'b1;
            default: wr_hit = 1'b0;
        endcase
    end

    assign axil_rsp = '{
        awready: wr_go,
        wready:  wr_go,
        arready: !rvalid,
        bvalid:  bvalid,
        bresp:   bresp,
        rvalid:  rvalid,
        rdata:   rdata,
        rresp:   rresp
    };

    always_ff @(posedge sim_clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            din <= '0;
            halt_en <= 1'b0;
        end else begin
            if (wr_go) begin
                bvalid <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid <= 1'b0;
            end
            if (rd_go) begin
                rvalid <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid <= 1'b0;
            end
            if (wr_go && axil_req.awaddr == `LVDA_REG_DIN) begin
                for (int b = 0; b < `LVDA_DIN_W / 8; b++) begin
                    if (axil_req.wstrb[b]) begin
                        din[8*b +: 8] <= axil_req.wdata[8*b +: 8];
                    end
                end
            end
            if (wr_go && axil_req.awaddr == `LVDA_REG_CTRL && axil_req.wstrb[0]) begin
                halt_en <= axil_req.wdata[0];
            end
        end
    end

    // status is read-only, so a write there is accepted and ignored.
    always_ff @(posedge sim_clk) begin
        if (wr_go) begin
            bresp <= wr_hit ? resp_okay : resp_slverr;
        end
        if (rd_go) begin
            rresp <= resp_okay;
            case (axil_req.araddr)
                `LVDA_REG_DIN: rdata <= axil_data_t'(din);
                `LVDA_REG_CTRL: rdata <= axil_data_t'(halt_en);
                `LVDA_REG_STATUS: rdata <= status;
                default: begin
                    rdata <= '0;
                    rresp <= resp_slverr;
                end
            endcase
        end
    end

endmodule

// ==== design/lvda_timing.sv ====
`timescale 1ns/1ps

module lvda_timing
    import lvda_pkg::*;
(
    input  logic   sim_clk,
    input  logic   rst,
    input  logic   hlt,
    input  logic   cst,
    input  logic   halt_en,
    output phase_t phase,
    output logic   halt,
    output logic   cstn
);

    phase_t phase_nxt;

    always_comb begin
        case (phase)
            phase_w: phase_nxt = phase_x;
            phase_x: phase_nxt = phase_y;
            phase_y: phase_nxt = phase_z;
            default: phase_nxt = phase_w;
        endcase
    end

    always_ff @(posedge sim_clk) begin
        if (rst) begin
            phase <= phase_w;
        end else begin
            phase <= phase_nxt;
        end
    end

    // computer start clears the latch and takes priority over a new halt.
    always_ff @(posedge sim_clk) begin
        if (rst) begin
            halt <= 1'b0;
            cstn <= 1'b1;
        end else begin
            cstn <= ~cst;
            if (cst) begin
                halt <= 1'b0;
            end else if (phase == phase_z && hlt && halt_en) begin
                halt <= 1'b1;
            end
        end
    end

endmodule

// ==== common/lvda_pkg.sv ====
`include "lvda_cfg.svh"

package lvda_pkg;

    // the four timing phases, in the order they occur.
    typedef enum logic [1:0] {
        phase_w,
        phase_x,
        phase_y,
        phase_z
    } phase_t;

    // all discrete inputs as one word.
    typedef logic [`LVDA_DIN_W-1:0] din_t;

    // group select for a discrete read.
    typedef logic [$clog2(`LVDA_DIN_W / `LVDA_GROUP_W)-1:0] din_group_t;

    // read request from the command decoder to the sampler.
    typedef struct packed {
        logic       valid;
        din_group_t group;
    } din_req_t;

    // serial data line, strobed once per bit.
    typedef struct packed {
        logic data;
        logic data_strobe;
    } serial_out_t;

endpackage

// ==== common/axil_pkg.sv ====
package axil_pkg;

    typedef logic [3:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [3:0] axil_strb_t;
    typedef logic [1:0] axil_resp_t;

    localparam axil_resp_t resp_okay = 2'b00;
    localparam axil_resp_t resp_slverr = 2'b10;

    // manager to subordinate.
    typedef struct packed {
        logic       awvalid;
        axil_addr_t awaddr;
        logic       wvalid;
        axil_data_t wdata;
        axil_strb_t wstrb;
        logic       bready;
        logic       arvalid;
        axil_addr_t araddr;
        logic       rready;
    } axil_req_t;

    // subordinate to manager.
    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       arready;
        logic       bvalid;
        axil_resp_t bresp;
        logic       rvalid;
        axil_data_t rdata;
        axil_resp_t rresp;
    } axil_rsp_t;

endpackage

// ==== common/lvda_cfg.svh ====
`ifndef LVDA_CFG_SVH
`define LVDA_CFG_SVH

// processor I/O address width.
`define LVDA_ADDR_W 9

// discrete inputs are read in groups of eight bits.
`define LVDA_DIN_W 24
`define LVDA_GROUP_W 8

// top three address bits of a discrete-input read command.
`define LVDA_DIN_READ_OP 3'b101

// register byte offsets on the AXI4-Lite bus.
`define LVDA_REG_DIN 4'h0
`define LVDA_REG_CTRL 4'h4
`define LVDA_REG_STATUS 4'h8

`endif
